// ==== source/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    localparam int rob_depth = 32;   // buffer entries
    localparam int dec_width = 4;    // dispatch lanes
    localparam int exe_width = 3;    // completion ports
    localparam int com_width = 4;    // commit lanes
    localparam int xlen      = 64;

    localparam int tag_bits   = $clog2(rob_depth);
    localparam int count_bits = tag_bits + 1;   // must hold rob_depth itself

    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [count_bits-1:0] count_t;
    typedef logic [xlen-1:0]       addr_t;

    // bit 7 flags a fault, bits 6:0 carry the code
    typedef logic [7:0] cause_t;

    localparam addr_t reset_pc = 64'h0000_0000_8000_0000;

    // written at dispatch, read at commit
    typedef struct packed {
        addr_t      pc;
        logic [4:0] rd;
    } rob_dec_t;

    // written at completion, read at commit
    typedef struct packed {
        addr_t  npc;
        cause_t cause;
    } rob_exe_t;

endpackage

`default_nettype wire

// ==== source/rob_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_ram #(
    parameter type entry_t     = logic,
    parameter int  write_ports = 1
) (
    input  logic          clk,
    input  logic          wena  [write_ports],
    input  rob_pkg::tag_t waddr [write_ports],
    input  entry_t        wdata [write_ports],
    input  rob_pkg::tag_t raddr [rob_pkg::com_width],
    output entry_t        rdata [rob_pkg::com_width]
);
    import rob_pkg::*;

    entry_t mem [rob_depth];

    always_ff @(posedge clk) begin
        for (int i = 0; i < write_ports; i++) begin
            if (wena[i]) begin
                mem[waddr[i]] <= wdata[i];   // later port wins, see check below
            end
        end
    end

    // read ports see the array as of the last edge
    always_comb begin
        for (int i = 0; i < com_width; i++) begin
            rdata[i] = mem[raddr[i]];
        end
    end

    // two writers on one entry means the allocator or execute handed out a tag twice
    for (genvar i = 0; i < write_ports; i++) begin : g_wport
        for (genvar j = i + 1; j < write_ports; j++) begin : g_pair
            a_no_write_clash: assert property (
                @(posedge clk) !(wena[i] && wena[j] && waddr[i] == waddr[j])
            ) else $error("rob_ram: ports %0d and %0d write entry %0d", i, j, waddr[i]);
        end
    end

endmodule

`default_nettype wire

// ==== source/rob_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_dispatch (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              dec_valid    [rob_pkg::dec_width],
    input  rob_pkg::addr_t    dec_pc       [rob_pkg::dec_width],
    input  logic [4:0]        dec_rd       [rob_pkg::dec_width],
    input  rob_pkg::count_t   retire_count,
    input  rob_pkg::tag_t     rd_tag       [rob_pkg::com_width],
    output rob_pkg::tag_t     dec_tag      [rob_pkg::dec_width],
    output rob_pkg::count_t   rob_free,
    output rob_pkg::count_t   rob_count,
    output rob_pkg::rob_dec_t slot_dec     [rob_pkg::com_width]
);
    import rob_pkg::*;

    tag_t     tail;
    count_t   n_dec;                     // lanes taken this cycle
    logic     wena  [dec_width];
    rob_dec_t wdata [dec_width];

    always_comb begin
        n_dec = '0;
        for (int i = 0; i < dec_width; i++) begin
            dec_tag[i]  = tail + tag_t'(i);
            wena[i]     = dec_valid[i] && !flush;   // lanes in a redirect cycle are dropped
            wdata[i].pc = dec_pc[i];
            wdata[i].rd = dec_rd[i];
            if (wena[i]) begin
                n_dec = n_dec + count_t'(1);
            end
        end
    end

    assign rob_free = count_t'(rob_depth) - rob_count;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail      <= '0;
            rob_count <= '0;
        end else begin
            tail      <= tail + tag_t'(n_dec);   // wraps at rob_depth
            rob_count <= rob_count + n_dec - retire_count;
        end
    end

    rob_ram #(
        .entry_t     (rob_dec_t),
        .write_ports (dec_width)
    ) u_dec_ram (
        .clk   (clk),
        .wena  (wena),
        .waddr (dec_tag),
        .wdata (wdata),
        .raddr (rd_tag),
        .rdata (slot_dec)
    );

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) n_dec <= rob_free
    ) else $error("rob_dispatch: %0d lanes with only %0d free", n_dec, rob_free);

endmodule

`default_nettype wire

// ==== source/rob_complete.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_complete (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  rob_pkg::tag_t     front,
    input  logic              exe_valid [rob_pkg::exe_width],
    input  rob_pkg::tag_t     exe_tag   [rob_pkg::exe_width],
    input  rob_pkg::addr_t    exe_npc   [rob_pkg::exe_width],
    input  rob_pkg::cause_t   exe_cause [rob_pkg::exe_width],
    input  rob_pkg::addr_t    exe_tval  [rob_pkg::exe_width],
    input  rob_pkg::tag_t     rd_tag    [rob_pkg::com_width],
    input  logic              com_valid [rob_pkg::com_width],
    input  rob_pkg::tag_t     com_tag   [rob_pkg::com_width],
    output logic              slot_done [rob_pkg::com_width],
    output rob_pkg::rob_exe_t slot_exe  [rob_pkg::com_width],
    output rob_pkg::addr_t    fault_tval
);
    import rob_pkg::*;

    logic [rob_depth-1:0] done;          // one bit per entry
    rob_exe_t             wdata    [exe_width];
    rob_exe_t             ram_exe  [com_width];

    logic  fault_valid;                  // oldest fault seen so far
    tag_t  fault_tag;
    logic  fault_valid_nxt;
    tag_t  fault_tag_nxt;
    addr_t fault_tval_nxt;

    always_comb begin
        for (int i = 0; i < exe_width; i++) begin
            wdata[i].npc   = exe_npc[i] & ~addr_t'(1);   // keep fetch halfword aligned
            wdata[i].cause = exe_cause[i];
        end
    end

    rob_ram #(
        .entry_t     (rob_exe_t),
        .write_ports (exe_width)
    ) u_exe_ram (
        .clk   (clk),
        .wena  (exe_valid),
        .waddr (exe_tag),
        .wdata (wdata),
        .raddr (rd_tag),
        .rdata (ram_exe)
    );

    // a result arriving this cycle is visible to commit right away
    always_comb begin
        for (int i = 0; i < com_width; i++) begin
            slot_done[i] = done[rd_tag[i]];
            slot_exe[i]  = ram_exe[i];
            for (int j = 0; j < exe_width; j++) begin
                if (exe_valid[j] && exe_tag[j] == rd_tag[i]) begin
                    slot_done[i] = 1'b1;
                    slot_exe[i]  = wdata[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            done <= '0;
        end else begin
            for (int j = 0; j < exe_width; j++) begin
                if (exe_valid[j]) begin
                    done[exe_tag[j]] <= 1'b1;
                end
            end
            for (int i = 0; i < com_width; i++) begin
                if (com_valid[i]) begin
                    done[com_tag[i]] <= 1'b0;   // after the set, so same-cycle commit frees it
                end
            end
        end
    end

    // age is the distance from front, smaller is older
    always_comb begin
        fault_valid_nxt = fault_valid;
        fault_tag_nxt   = fault_tag;
        fault_tval_nxt  = fault_tval;
        for (int j = 0; j < exe_width; j++) begin
            if (exe_valid[j] && exe_cause[j][7] &&
                (!fault_valid_nxt || tag_t'(exe_tag[j] - front) < tag_t'(fault_tag_nxt - front))) begin
                fault_valid_nxt = 1'b1;
                fault_tag_nxt   = exe_tag[j];
                fault_tval_nxt  = exe_tval[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            fault_valid <= 1'b0;
            fault_tag   <= '0;
            fault_tval  <= '0;
        end else begin
            fault_valid <= fault_valid_nxt;
            fault_tag   <= fault_tag_nxt;
            fault_tval  <= fault_tval_nxt;
        end
    end

    for (genvar j = 0; j < exe_width; j++) begin : g_exe_chk
        a_single_completion: assert property (
            @(posedge clk) disable iff (rst) exe_valid[j] |-> !done[exe_tag[j]]
        ) else $error("rob_complete: tag %0d completed twice", exe_tag[j]);
    end

endmodule

`default_nettype wire

// ==== source/rob_retire.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_retire (
    input  logic              clk,
    input  logic              rst,
    input  rob_pkg::count_t   rob_count,
    input  rob_pkg::rob_dec_t slot_dec  [rob_pkg::com_width],
    input  logic              slot_done [rob_pkg::com_width],
    input  rob_pkg::rob_exe_t slot_exe  [rob_pkg::com_width],
    input  rob_pkg::addr_t    fault_tval,
    input  rob_pkg::addr_t    tvec,
    output rob_pkg::tag_t     front,
    output rob_pkg::tag_t     rd_tag    [rob_pkg::com_width],
    output rob_pkg::count_t   retire_count,
    output logic              com_valid [rob_pkg::com_width],
    output rob_pkg::tag_t     com_tag   [rob_pkg::com_width],
    output rob_pkg::addr_t    com_pc    [rob_pkg::com_width],
    output logic [4:0]        com_rd    [rob_pkg::com_width],
    output logic              redir,
    output rob_pkg::addr_t    redir_pc,
    output logic              exception,
    output rob_pkg::addr_t    epc,
    output rob_pkg::cause_t   cause,
    output rob_pkg::addr_t    tval
);
    import rob_pkg::*;

    addr_t    last_pc;                   // most recently committed entry
    rob_exe_t last_exe;
    logic     last_fault;

    logic [com_width-1:0] lane_redir;    // lane breaks the predicted path
    rob_dec_t             sel_dec;       // youngest lane committing now
    rob_exe_t             sel_exe;

    always_comb begin
        for (int i = 0; i < com_width; i++) begin
            rd_tag[i]  = front + tag_t'(i);
            com_tag[i] = rd_tag[i];
            com_pc[i]  = slot_dec[i].pc;
            com_rd[i]  = slot_dec[i].rd;
        end
    end

    // slot 0 is checked against the registered last commit
    assign last_fault = last_exe.cause[7];
    assign redir      = (rob_count != '0 && slot_dec[0].pc != last_exe.npc) || last_fault;
    assign redir_pc   = last_fault ? tvec : last_exe.npc;
    assign exception  = last_fault;
    assign epc        = last_pc;
    assign cause      = last_exe.cause;
    assign tval       = fault_tval;

    always_comb begin
        lane_redir[0] = redir;
        for (int i = 1; i < com_width; i++) begin
            lane_redir[i] = slot_dec[i].pc != slot_exe[i-1].npc || slot_exe[i-1].cause[7];
        end
    end

    always_comb begin
        logic chain;
        chain        = 1'b1;
        retire_count = '0;
        sel_dec      = slot_dec[0];
        sel_exe      = slot_exe[0];
        for (int i = 0; i < com_width; i++) begin
            com_valid[i] = chain && slot_done[i] && !lane_redir[i] &&
                           count_t'(i) < rob_count;
            chain = com_valid[i];        // stop at the first lane that cannot go
            if (com_valid[i]) begin
                retire_count = retire_count + count_t'(1);
                sel_dec      = slot_dec[i];
                sel_exe      = slot_exe[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redir) begin
            front <= '0;                 // buffer empties with the redirect
        end else begin
            front <= front + tag_t'(retire_count);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_exe.npc   <= reset_pc;
            last_exe.cause <= '0;
        end else if (retire_count != '0) begin
            last_exe <= sel_exe;
        end else if (redir) begin
            last_exe.npc   <= redir_pc;  // fetch restarts here
            last_exe.cause <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_count != '0) begin
            last_pc <= sel_dec.pc;
        end
    end

    for (genvar i = 1; i < com_width; i++) begin : g_lane_chk
        a_contiguous: assert property (
            @(posedge clk) disable iff (rst) com_valid[i] |-> com_valid[i-1]
        ) else $error("rob_retire: commit lane %0d valid without lane %0d", i, i - 1);
    end

    // the flush reaches dispatch, so the next cycle sees an empty buffer
    a_redir_empties: assert property (
        @(posedge clk) disable iff (rst) redir |=> rob_count == '0 && !redir
    ) else $error("rob_retire: buffer not empty after redirect");

endmodule

`default_nettype wire

// ==== source/rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            dec_valid [rob_pkg::dec_width],
    input  rob_pkg::addr_t  dec_pc    [rob_pkg::dec_width],
    input  logic [4:0]      dec_rd    [rob_pkg::dec_width],
    output rob_pkg::tag_t   dec_tag   [rob_pkg::dec_width],
    output rob_pkg::count_t rob_free,
    input  logic            exe_valid [rob_pkg::exe_width],
    input  rob_pkg::tag_t   exe_tag   [rob_pkg::exe_width],
    input  rob_pkg::addr_t  exe_npc   [rob_pkg::exe_width],
    input  rob_pkg::cause_t exe_cause [rob_pkg::exe_width],
    input  rob_pkg::addr_t  exe_tval  [rob_pkg::exe_width],
    output logic            com_valid [rob_pkg::com_width],
    output rob_pkg::tag_t   com_tag   [rob_pkg::com_width],
    output rob_pkg::addr_t  com_pc    [rob_pkg::com_width],
    output logic [4:0]      com_rd    [rob_pkg::com_width],
    output logic            redir,
    output rob_pkg::addr_t  redir_pc,
    output logic            exception,
    output rob_pkg::addr_t  epc,
    output rob_pkg::cause_t cause,
    output rob_pkg::addr_t  tval,
    input  rob_pkg::addr_t  tvec
);
    import rob_pkg::*;

    count_t   rob_count;
    count_t   retire_count;
    tag_t     front;
    tag_t     rd_tag    [com_width];     // oldest com_width entries
    rob_dec_t slot_dec  [com_width];
    logic     slot_done [com_width];
    rob_exe_t slot_exe  [com_width];
    addr_t    fault_tval;

    rob_dispatch u_dispatch (
        .clk(clk), .rst(rst), .flush(redir),
        .dec_valid(dec_valid), .dec_pc(dec_pc), .dec_rd(dec_rd),
        .retire_count(retire_count), .rd_tag(rd_tag),
        .dec_tag(dec_tag), .rob_free(rob_free), .rob_count(rob_count),
        .slot_dec(slot_dec)
    );

    rob_complete u_complete (
        .clk(clk), .rst(rst), .flush(redir), .front(front),
        .exe_valid(exe_valid), .exe_tag(exe_tag), .exe_npc(exe_npc),
        .exe_cause(exe_cause), .exe_tval(exe_tval),
        .rd_tag(rd_tag), .com_valid(com_valid), .com_tag(com_tag),
        .slot_done(slot_done), .slot_exe(slot_exe), .fault_tval(fault_tval)
    );

    rob_retire u_retire (
        .clk(clk), .rst(rst), .rob_count(rob_count),
        .slot_dec(slot_dec), .slot_done(slot_done), .slot_exe(slot_exe),
        .fault_tval(fault_tval), .tvec(tvec),
        .front(front), .rd_tag(rd_tag), .retire_count(retire_count),
        .com_valid(com_valid), .com_tag(com_tag), .com_pc(com_pc), .com_rd(com_rd),
        .redir(redir), .redir_pc(redir_pc), .exception(exception),
        .epc(epc), .cause(cause), .tval(tval)
    );

endmodule

`default_nettype wire

// ==== dv/rob_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_checker (
    input  logic            clk,
    input  logic            rst,
    input  logic            dec_valid [rob_pkg::dec_width],
    input  rob_pkg::tag_t   dec_tag   [rob_pkg::dec_width],
    input  logic            com_valid [rob_pkg::com_width],
    input  rob_pkg::tag_t   com_tag   [rob_pkg::com_width],
    input  rob_pkg::addr_t  com_pc    [rob_pkg::com_width],
    input  logic [4:0]      com_rd    [rob_pkg::com_width],
    input  logic            redir,
    input  rob_pkg::addr_t  redir_pc,
    input  logic            exception,
    input  rob_pkg::addr_t  epc,
    input  rob_pkg::cause_t cause,
    input  rob_pkg::addr_t  tval,
    input  rob_pkg::addr_t  tvec,
    input  rob_pkg::count_t rob_free
);
    import rob_pkg::*;

    int    n_pass = 0;
    int    n_fail = 0;
    logic  active = 1'b0;
    string name;
    string msg;                          // first wrong value of the row
    string plain;                        // first protocol problem of the row

    int     n_ins;                       // instructions dispatched by the row
    int     last_idx;                    // youngest index expected to commit
    logic   want_redir;
    logic   want_exc;
    addr_t  want_pc;
    addr_t  want_epc;
    cause_t want_cause;
    addr_t  want_tval;
    addr_t  base_pc;
    tag_t   tag0;

    tag_t       got_dtag [$];            // tags handed out at dispatch
    tag_t       got_tag [$];
    addr_t      got_pc  [$];
    logic [4:0] got_rd  [$];
    int         n_redir;
    logic       got_exc;
    addr_t      got_rpc;
    addr_t      got_epc;
    addr_t      got_tval;
    cause_t     got_cause;

    always @(negedge clk) begin
        if (active && !rst) begin
            for (int i = 0; i < dec_width; i++) begin
                if (dec_valid[i]) begin
                    got_dtag.push_back(dec_tag[i]);
                end
            end
            for (int i = 0; i < com_width; i++) begin
                if (com_valid[i]) begin
                    if (i > 0 && !com_valid[i-1] && plain == "") begin
                        plain = "commit lanes are not contiguous";
                    end
                    got_tag.push_back(com_tag[i]);
                    got_pc.push_back(com_pc[i]);
                    got_rd.push_back(com_rd[i]);
                end
            end
            if (redir) begin
                if (com_valid[0] && plain == "") begin
                    plain = "an entry committed during the redirect cycle";
                end
                if (n_redir == 0) begin   // keep the first redirect
                    got_rpc   = redir_pc;
                    got_exc   = exception;
                    got_epc   = epc;
                    got_cause = cause;
                    got_tval  = tval;
                end
                n_redir++;
            end
        end
    end

    function automatic void compare(string field, logic [63:0] want, logic [63:0] got);
        if (want !== got && msg == "") begin
            msg = $sformatf("Error: %s %s expected %0h actual %0h", name, field, want, got);
        end
    endfunction

    function automatic void tally();
        if (msg == "" && plain == "") begin
            n_pass++;
            $display("ok    %s", name);
        end else if (msg != "") begin
            n_fail++;
            $display("%s", msg);
        end else begin
            n_fail++;
            $display("fail  %s: %s", name, plain);
        end
    endfunction

    function automatic void check_reset();
        name  = "reset";
        msg   = "";
        plain = "";
        for (int i = 0; i < com_width; i++) begin
            compare($sformatf("com_valid[%0d]", i), 0, com_valid[i]);
        end
        compare("redir", 0, redir);
        compare("exception", 0, exception);
        compare("rob_free", rob_depth, rob_free);
        tally();
    endfunction

    // commit stops at the first mispredict or fault, a redirect needs a younger entry or a fault
    function automatic void expect_row(string nm, int n, addr_t base, tag_t t0, int mis,
                                       int flt, cause_t fc, addr_t ft);
        name  = nm;
        msg   = "";
        plain = "";
        got_dtag.delete();
        got_tag.delete();
        got_pc.delete();
        got_rd.delete();
        n_redir    = 0;
        n_ins      = n;
        base_pc    = base;
        tag0       = t0;
        last_idx   = n - 1;
        if (mis >= 0 && mis < last_idx) last_idx = mis;
        if (flt >= 0 && flt <= last_idx) last_idx = flt;
        want_exc   = flt >= 0 && flt == last_idx;
        want_redir = want_exc || (mis == last_idx && last_idx < n - 1);
        want_pc    = want_exc ? tvec : base + 64'h400;
        want_epc   = base + addr_t'(4 * flt);
        want_cause = fc;
        want_tval  = ft;
        active     = 1'b1;
    endfunction

    function automatic void finish_row();
        active = 1'b0;
        compare("dispatch count", n_ins, got_dtag.size());
        for (int i = 0; i < n_ins && i < got_dtag.size(); i++) begin
            compare($sformatf("dec_tag[%0d]", i), tag_t'(tag0 + tag_t'(i)), got_dtag[i]);
        end
        compare("commit count", last_idx + 1, got_tag.size());
        for (int i = 0; i <= last_idx && i < got_tag.size(); i++) begin
            compare($sformatf("tag[%0d]", i), tag_t'(tag0 + tag_t'(i)), got_tag[i]);
            compare($sformatf("pc[%0d]", i), base_pc + addr_t'(4 * i), got_pc[i]);
            compare($sformatf("rd[%0d]", i), 5'(i + 1), got_rd[i]);
        end
        compare("redirect count", want_redir, n_redir);
        if (want_redir && n_redir > 0) begin
            compare("redir_pc", want_pc, got_rpc);
            compare("exception", want_exc, got_exc);
            if (want_exc) begin
                compare("epc", want_epc, got_epc);
                compare("cause", want_cause, got_cause);
                compare("tval", want_tval, got_tval);
            end
        end
        tally();
    endfunction

endmodule

`default_nettype wire

// ==== dv/rob_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_tb;
    import rob_pkg::*;

    localparam int    n_rows   = 8;
    localparam int    timeout  = 200;
    localparam addr_t trap_vec = 64'h0000_0000_8000_2000;

    typedef struct packed {
        int     n;                       // instructions in the row
        addr_t  base;
        int     mis;                     // -1 when none
        int     flt;                     // -1 when none
        cause_t fcause;
        addr_t  ftval;
        int     flt2;                    // younger second fault, -1 when none
    } row_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       dec_valid [dec_width];
    addr_t      dec_pc    [dec_width];
    logic [4:0] dec_rd    [dec_width];
    tag_t       dec_tag   [dec_width];
    count_t     rob_free;
    logic       exe_valid [exe_width];
    tag_t       exe_tag   [exe_width];
    addr_t      exe_npc   [exe_width];
    cause_t     exe_cause [exe_width];
    addr_t      exe_tval  [exe_width];
    logic       com_valid [com_width];
    tag_t       com_tag   [com_width];
    addr_t      com_pc    [com_width];
    logic [4:0] com_rd    [com_width];
    logic       redir;
    logic       exception;
    addr_t      redir_pc;
    addr_t      epc;
    addr_t      tval;
    addr_t      tvec;
    cause_t     cause;

    row_t  rows  [n_rows];
    string names [n_rows];
    tag_t  tail;                         // tag of the next dispatched entry
    int    timeouts;
    int    order [$];

    rob_top UUT (.*);

    rob_checker chk (.*);

    always #10 clk = ~clk;

    task automatic wait_free(int lanes);
        int t;
        for (t = 0; t < timeout; t++) begin
            @(negedge clk);
            if (rob_free >= count_t'(lanes)) break;
        end
        if (t == timeout) begin
            timeouts++;
            $display("timeout: %0d free entries never became available", lanes);
        end
    endtask

    task automatic dispatch_row(row_t r);
        int lanes;
        for (int g = 0; g < r.n; g += dec_width) begin
            lanes = (r.n - g < dec_width) ? r.n - g : dec_width;
            wait_free(lanes);
            @(posedge clk);
            for (int l = 0; l < dec_width; l++) begin
                dec_valid[l] <= (l < lanes);
                dec_pc[l]    <= r.base + addr_t'(4 * (g + l));   // pcs step by 4
                dec_rd[l]    <= 5'(g + l + 1);
            end
        end
        @(posedge clk);
        for (int l = 0; l < dec_width; l++) dec_valid[l] <= 1'b0;
    endtask

    // entries past the last one to commit are never completed, they get flushed
    task automatic complete_row(row_t r, int last);
        int j;
        int tmp;
        int k;
        int idx;
        order.delete();
        for (int i = 0; i <= last; i++) order.push_back(i);
        for (int i = last; i > 0; i--) begin
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        if (r.flt2 >= 0) order.push_front(r.flt2);   // younger fault goes first
        while (order.size() > 0) begin
            k = (order[0] == r.flt2) ? 1 : 1 + $urandom % exe_width;
            @(posedge clk);
            for (int p = 0; p < exe_width; p++) begin
                exe_valid[p] <= 1'b0;
                if (p < k && order.size() > 0) begin
                    idx = order.pop_front();
                    exe_valid[p] <= 1'b1;
                    exe_tag[p]   <= tail + tag_t'(idx);
                    exe_npc[p]   <= (idx == r.mis) ? r.base + 64'h400
                                                   : r.base + addr_t'(4 * idx + 4);
                    exe_cause[p] <= (idx == r.flt || idx == r.flt2) ? r.fcause : 8'h00;
                    exe_tval[p]  <= (idx == r.flt2) ? r.ftval + 64'h100 : r.ftval;
                end
            end
        end
        @(posedge clk);
        for (int p = 0; p < exe_width; p++) exe_valid[p] <= 1'b0;
    endtask

    task automatic drain();
        int t;
        for (t = 0; t < timeout; t++) begin
            @(negedge clk);
            if (rob_free == count_t'(rob_depth) && !redir) break;
        end
        if (t == timeout) begin
            timeouts++;
            $display("timeout: the buffer did not drain after the row");
        end
        repeat (2) @(posedge clk);
    endtask

    initial begin
        void'($urandom(14199));
        rst      = 1'b1;
        tvec     = trap_vec;
        tail     = '0;
        timeouts = 0;
        for (int i = 0; i < dec_width; i++) begin
            dec_valid[i] = 1'b0;
            dec_pc[i]    = '0;
            dec_rd[i]    = '0;
        end
        for (int i = 0; i < exe_width; i++) begin
            exe_valid[i] = 1'b0;
            exe_tag[i]   = '0;
            exe_npc[i]   = '0;
            exe_cause[i] = '0;
            exe_tval[i]  = '0;
        end
        // each base is the next pc left behind by the row before
        names[0] = "in_order_full";
        rows[0]  = '{12, 64'h8000_0000, -1, -1, 8'h00, 64'h0, -1};
        names[1] = "in_order_short";
        rows[1]  = '{7, 64'h8000_0030, -1, -1, 8'h00, 64'h0, -1};
        names[2] = "mispredict";
        rows[2]  = '{10, 64'h8000_004c, 3, -1, 8'h00, 64'h0, -1};
        names[3] = "exception";
        rows[3]  = '{9, 64'h8000_044c, -1, 5, 8'h82, 64'hdead_beef, -1};
        names[4] = "oldest_tval";
        rows[4]  = '{8, 64'h8000_2000, -1, 2, 8'h85, 64'h1234_5678, 6};
        names[5] = "refill_a";
        rows[5]  = '{12, 64'h8000_2000, -1, -1, 8'h00, 64'h0, -1};
        names[6] = "refill_b";
        rows[6]  = '{12, 64'h8000_2030, -1, -1, 8'h00, 64'h0, -1};
        names[7] = "wrap_mispredict";
        rows[7]  = '{12, 64'h8000_2060, 9, -1, 8'h00, 64'h0, -1};   // tags wrap past 31

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        chk.check_reset();
        for (int r = 0; r < n_rows; r++) begin
            chk.expect_row(names[r], rows[r].n, rows[r].base, tail, rows[r].mis,
                           rows[r].flt, rows[r].fcause, rows[r].ftval);
            dispatch_row(rows[r]);
            complete_row(rows[r], chk.last_idx);
            drain();
            chk.finish_row();
            tail = chk.want_redir ? tag_t'(0) : tail + tag_t'(rows[r].n);
        end
        $display("%0d passed, %0d failed, %0d timeouts", chk.n_pass, chk.n_fail, timeouts);
        if (chk.n_fail == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rob_lite.f ====
source/rob_pkg.sv
source/rob_ram.sv
source/rob_dispatch.sv
source/rob_complete.sv
source/rob_retire.sv
source/rob_top.sv
dv/rob_checker.sv
dv/rob_tb.sv

// ==== Bender.yml ====
package:
  name: rob_lite

sources:
  - files:
      - source/rob_pkg.sv
      - source/rob_ram.sv
      - source/rob_dispatch.sv
      - source/rob_complete.sv
      - source/rob_retire.sv
      - source/rob_top.sv
  - target: simulation
    files:
      - dv/rob_checker.sv
      - dv/rob_tb.sv
